// File: source/segre_core.sv
`timescale 1ns/10ps

module segre_core (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] wb_dat_i,
    input  logic                            wb_ack_i,
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic                            wb_we_o,
    output logic [segre_pkg::ADDR_SIZE-1:0] wb_adr_o,
    output logic [segre_pkg::WORD_SIZE-1:0] wb_dat_o
);

// Fetch and data ports toward the arbiter
logic                                if_req;
logic [segre_pkg::ADDR_SIZE-1:0]     if_addr;
logic                                if_ack;
logic [segre_pkg::WORD_SIZE-1:0]     if_rdata;
logic                                dc_req;
logic                                dc_we;
logic [segre_pkg::ADDR_SIZE-1:0]     dc_addr;
logic [segre_pkg::WORD_SIZE-1:0]     dc_wdata;
logic                                dc_ack;
logic [segre_pkg::WORD_SIZE-1:0]     dc_rdata;

// IF to ID
logic [segre_pkg::WORD_SIZE-1:0]     if_instr;
logic [segre_pkg::ADDR_SIZE-1:0]     if_pc;
logic                                if_valid;

// ID/EX register contents
logic                                ex_valid;
logic [segre_pkg::ADDR_SIZE-1:0]     ex_pc;
segre_pkg::alu_opcode_e              ex_alu_opcode;
logic [segre_pkg::WORD_SIZE-1:0]     ex_src_a;
logic [segre_pkg::WORD_SIZE-1:0]     ex_src_b;
logic                                ex_rf_we;
logic [segre_pkg::REG_ADDR_SIZE-1:0] ex_rf_waddr;
segre_pkg::memop_e                   ex_memop;
logic [segre_pkg::WORD_SIZE-1:0]     ex_store_data;
segre_pkg::br_type_e                 ex_br_type;
logic [segre_pkg::WORD_SIZE-1:0]     ex_imm;

// Register file ports
logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_a;
logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_b;
logic [segre_pkg::WORD_SIZE-1:0]     rf_data_a;
logic [segre_pkg::WORD_SIZE-1:0]     rf_data_b;
logic                                rf_we;
logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr;
logic [segre_pkg::WORD_SIZE-1:0]     rf_wdata;

logic                                redirect;
logic [segre_pkg::ADDR_SIZE-1:0]     redirect_pc;
logic                                ex_busy;
logic                                id_stall;
logic                                id_hazard;
logic                                if_hazard;

// Hazard combination
assign id_hazard = ex_busy;
assign if_hazard = ex_busy | id_stall;

segre_if_stage if_stage (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .hazard_i      (if_hazard),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .if_ack_i      (if_ack),
    .if_rdata_i    (if_rdata),
    .if_req_o      (if_req),
    .if_addr_o     (if_addr),
    .instr_o       (if_instr),
    .pc_o          (if_pc),
    .instr_valid_o (if_valid)
);

segre_id_stage id_stage (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .hazard_i      (id_hazard),
    .flush_i       (redirect),
    .instr_i       (if_instr),
    .pc_i          (if_pc),
    .instr_valid_i (if_valid),
    .rf_data_a_i   (rf_data_a),
    .rf_data_b_i   (rf_data_b),
    .hazard_o      (id_stall),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .valid_o       (ex_valid),
    .pc_o          (ex_pc),
    .alu_opcode_o  (ex_alu_opcode),
    .alu_src_a_o   (ex_src_a),
    .alu_src_b_o   (ex_src_b),
    .rf_we_o       (ex_rf_we),
    .rf_waddr_o    (ex_rf_waddr),
    .memop_o       (ex_memop),
    .store_data_o  (ex_store_data),
    .br_type_o     (ex_br_type),
    .imm_o         (ex_imm)
);

segre_pipeline_wrapper pipeline_wrapper (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .valid_i       (ex_valid),
    .pc_i          (ex_pc),
    .alu_opcode_i  (ex_alu_opcode),
    .alu_src_a_i   (ex_src_a),
    .alu_src_b_i   (ex_src_b),
    .rf_we_i       (ex_rf_we),
    .rf_waddr_i    (ex_rf_waddr),
    .memop_i       (ex_memop),
    .store_data_i  (ex_store_data),
    .br_type_i     (ex_br_type),
    .imm_i         (ex_imm),
    .dc_ack_i      (dc_ack),
    .dc_rdata_i    (dc_rdata),
    .dc_req_o      (dc_req),
    .dc_we_o       (dc_we),
    .dc_addr_o     (dc_addr),
    .dc_wdata_o    (dc_wdata),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .ex_busy_o     (ex_busy)
);

segre_register_file segre_rf (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .data_a_o  (rf_data_a),
    .data_b_o  (rf_data_b)
);

segre_mem_arbiter mem_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .if_req_i   (if_req),
    .if_addr_i  (if_addr),
    .dc_req_i   (dc_req),
    .dc_we_i    (dc_we),
    .dc_addr_i  (dc_addr),
    .dc_wdata_i (dc_wdata),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i),
    .if_ack_o   (if_ack),
    .if_rdata_o (if_rdata),
    .dc_ack_o   (dc_ack),
    .dc_rdata_o (dc_rdata),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_we_o    (wb_we_o),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_o   (wb_dat_o)
);

endmodule : segre_core

// File: source/segre_id_stage.sv
`timescale 1ns/10ps

module segre_id_stage (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                hazard_i,
    input  logic                                flush_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     instr_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]     pc_i,
    input  logic                                instr_valid_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     rf_data_a_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     rf_data_b_i,
    output logic                                hazard_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_a_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_b_o,
    output logic                                valid_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]     pc_o,
    output segre_pkg::alu_opcode_e              alu_opcode_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     alu_src_a_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     alu_src_b_o,
    output logic                                rf_we_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr_o,
    output segre_pkg::memop_e                   memop_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     store_data_o,
    output segre_pkg::br_type_e                 br_type_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     imm_o
);

logic [6:0]                      opcode;
logic [2:0]                      funct3;
logic [segre_pkg::WORD_SIZE-1:0] imm_i_type;
logic [segre_pkg::WORD_SIZE-1:0] imm_s_type;
logic [segre_pkg::WORD_SIZE-1:0] imm_b_type;
logic [segre_pkg::WORD_SIZE-1:0] imm_u_type;
logic [segre_pkg::WORD_SIZE-1:0] imm_j_type;
segre_pkg::alu_opcode_e          alu_op;
segre_pkg::memop_e               memop;
segre_pkg::br_type_e             br_type;
logic                            use_imm;
logic                            rf_we;
logic [segre_pkg::WORD_SIZE-1:0] imm;

assign opcode = instr_i[6:0];
assign funct3 = instr_i[14:12];

assign rf_raddr_a_o = instr_i[19:15];
assign rf_raddr_b_o = instr_i[24:20];

// Only the execute stage can stall the core
assign hazard_o = hazard_i;

assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
assign imm_u_type = {instr_i[31:12], 12'b0};
assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};

always_comb begin
    alu_op  = segre_pkg::ALU_ADD;
    memop   = segre_pkg::MEMOP_NONE;
    br_type = segre_pkg::BR_NONE;
    use_imm = 1'b0;
    rf_we   = 1'b0;
    imm     = imm_i_type;
    case (opcode)
        segre_pkg::OPC_OP: begin
            rf_we = 1'b1;
            case ({instr_i[30], funct3})
                4'b0000: alu_op = segre_pkg::ALU_ADD;
                4'b1000: alu_op = segre_pkg::ALU_SUB;
                4'b0111: alu_op = segre_pkg::ALU_AND;
                4'b0110: alu_op = segre_pkg::ALU_OR;
                4'b0100: alu_op = segre_pkg::ALU_XOR;
                4'b0010: alu_op = segre_pkg::ALU_SLT;
                default: rf_we  = 1'b0;
            endcase
        end
        segre_pkg::OPC_OPIMM: begin
            // ADDI only
            rf_we   = (funct3 == 3'b000);
            use_imm = 1'b1;
        end
        segre_pkg::OPC_LUI: begin
            rf_we   = 1'b1;
            alu_op  = segre_pkg::ALU_PASS_B;
            use_imm = 1'b1;
            imm     = imm_u_type;
        end
        segre_pkg::OPC_LOAD: begin
            if (funct3 == 3'b010) begin
                rf_we = 1'b1;
                memop = segre_pkg::MEMOP_LOAD;
            end
            use_imm = 1'b1;
        end
        segre_pkg::OPC_STORE: begin
            if (funct3 == 3'b010) begin
                memop = segre_pkg::MEMOP_STORE;
            end
            use_imm = 1'b1;
            imm     = imm_s_type;
        end
        segre_pkg::OPC_BRANCH: begin
            imm = imm_b_type;
            if (funct3 == 3'b000) begin
                br_type = segre_pkg::BR_EQ;
            end else if (funct3 == 3'b001) begin
                br_type = segre_pkg::BR_NE;
            end
        end
        segre_pkg::OPC_JAL: begin
            rf_we   = 1'b1;
            br_type = segre_pkg::BR_JAL;
            imm     = imm_j_type;
        end
        default: ;
    endcase
end

// ID/EX register
always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        valid_o <= 1'b0;
    end else if (flush_i) begin
        valid_o <= 1'b0;
    end else if (!hazard_i) begin
        valid_o <= instr_valid_i;
    end
end

always_ff @(posedge clk_i) begin
    if (!hazard_i) begin
        pc_o         <= pc_i;
        alu_opcode_o <= alu_op;
        alu_src_a_o  <= rf_data_a_i;
        alu_src_b_o  <= use_imm ? imm : rf_data_b_i;
        rf_we_o      <= rf_we;
        rf_waddr_o   <= instr_i[11:7];
        memop_o      <= memop;
        store_data_o <= rf_data_b_i;
        br_type_o    <= br_type;
        imm_o        <= imm;
    end
end

endmodule : segre_id_stage

// File: source/segre_if_stage.sv
`timescale 1ns/10ps

module segre_if_stage (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              hazard_i,
    input  logic                              redirect_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]   redirect_pc_i,
    input  logic                              if_ack_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]   if_rdata_i,
    output logic                              if_req_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]   if_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]   instr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]   pc_o,
    output logic                              instr_valid_o
);

logic [segre_pkg::ADDR_SIZE-1:0] pc_q;
logic [segre_pkg::ADDR_SIZE-1:0] addr_q;
logic                            req_q;
logic                            drop_q;
logic                            issue;
logic                            fetched;

// A fetch starts only when decode will take the current word
assign issue   = !req_q && !hazard_i && !redirect_i;
// Words from a fetch issued before a redirect are thrown away
assign fetched = if_ack_i && !drop_q && !redirect_i;

assign if_req_o  = req_q | issue;
assign if_addr_o = req_q ? addr_q : pc_q;

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        pc_q          <= segre_pkg::RESET_PC;
        addr_q        <= segre_pkg::RESET_PC;
        req_q         <= 1'b0;
        drop_q        <= 1'b0;
        instr_valid_o <= 1'b0;
    end else begin
        if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (issue) begin
            pc_q <= pc_q + 4;
        end

        if (issue) begin
            req_q  <= 1'b1;
            addr_q <= pc_q;
        end else if (if_ack_i) begin
            req_q <= 1'b0;
        end

        // Remember a fetch still in flight across the redirect
        if (redirect_i) begin
            drop_q <= req_q && !if_ack_i;
        end else if (if_ack_i) begin
            drop_q <= 1'b0;
        end

        if (fetched) begin
            instr_valid_o <= 1'b1;
        end else if (redirect_i || !hazard_i) begin
            instr_valid_o <= 1'b0;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (fetched) begin
        instr_o <= if_rdata_i;
        pc_o    <= addr_q;
    end
end

endmodule : segre_if_stage

// File: source/segre_mem_arbiter.sv
`timescale 1ns/10ps

module segre_mem_arbiter (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            if_req_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0] if_addr_i,
    input  logic                            dc_req_i,
    input  logic                            dc_we_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0] dc_addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] dc_wdata_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] wb_dat_i,
    input  logic                            wb_ack_i,
    output logic                            if_ack_o,
    output logic [segre_pkg::WORD_SIZE-1:0] if_rdata_o,
    output logic                            dc_ack_o,
    output logic [segre_pkg::WORD_SIZE-1:0] dc_rdata_o,
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic                            wb_we_o,
    output logic [segre_pkg::ADDR_SIZE-1:0] wb_adr_o,
    output logic [segre_pkg::WORD_SIZE-1:0] wb_dat_o
);

typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_FETCH,
    ARB_DATA
} arb_state_e;

arb_state_e state_q;

// Grant only from idle, data port first; a transfer ends on ack
always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        state_q <= ARB_IDLE;
    end else begin
        case (state_q)
            ARB_IDLE: begin
                if (dc_req_i) begin
                    state_q <= ARB_DATA;
                end else if (if_req_i) begin
                    state_q <= ARB_FETCH;
                end
            end
            default: begin
                if (wb_ack_i) begin
                    state_q <= ARB_IDLE;
                end
            end
        endcase
    end
end

// Clients hold their fields until ack, so the bus follows the owner
assign wb_cyc_o = (state_q != ARB_IDLE);
assign wb_stb_o = (state_q != ARB_IDLE);
assign wb_we_o  = (state_q == ARB_DATA) && dc_we_i;
assign wb_adr_o = (state_q == ARB_DATA) ? dc_addr_i : if_addr_i;
assign wb_dat_o = dc_wdata_i;

assign if_ack_o   = (state_q == ARB_FETCH) && wb_ack_i;
assign if_rdata_o = wb_dat_i;
assign dc_ack_o   = (state_q == ARB_DATA) && wb_ack_i;
assign dc_rdata_o = wb_dat_i;

endmodule : segre_mem_arbiter

// File: source/segre_pipeline_wrapper.sv
`timescale 1ns/10ps

module segre_pipeline_wrapper (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                valid_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]     pc_i,
    input  segre_pkg::alu_opcode_e              alu_opcode_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     alu_src_a_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     alu_src_b_i,
    input  logic                                rf_we_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr_i,
    input  segre_pkg::memop_e                   memop_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     store_data_i,
    input  segre_pkg::br_type_e                 br_type_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     imm_i,
    input  logic                                dc_ack_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     dc_rdata_i,
    output logic                                dc_req_o,
    output logic                                dc_we_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]     dc_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     dc_wdata_o,
    output logic                                rf_we_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     rf_wdata_o,
    output logic                                redirect_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]     redirect_pc_o,
    output logic                                ex_busy_o
);

logic [segre_pkg::WORD_SIZE-1:0] alu_res;
logic                            is_mem;
logic                            br_taken;

always_comb begin
    case (alu_opcode_i)
        segre_pkg::ALU_SUB:    alu_res = alu_src_a_i - alu_src_b_i;
        segre_pkg::ALU_AND:    alu_res = alu_src_a_i & alu_src_b_i;
        segre_pkg::ALU_OR:     alu_res = alu_src_a_i | alu_src_b_i;
        segre_pkg::ALU_XOR:    alu_res = alu_src_a_i ^ alu_src_b_i;
        segre_pkg::ALU_SLT:    alu_res = {31'b0, $signed(alu_src_a_i) < $signed(alu_src_b_i)};
        segre_pkg::ALU_PASS_B: alu_res = alu_src_b_i;
        default:               alu_res = alu_src_a_i + alu_src_b_i;
    endcase
end

// Branch compare works on the two register operands
always_comb begin
    case (br_type_i)
        segre_pkg::BR_EQ:  br_taken = (alu_src_a_i == alu_src_b_i);
        segre_pkg::BR_NE:  br_taken = (alu_src_a_i != alu_src_b_i);
        segre_pkg::BR_JAL: br_taken = 1'b1;
        default:           br_taken = 1'b0;
    endcase
end

assign redirect_o    = valid_i && br_taken;
assign redirect_pc_o = pc_i + imm_i;

assign is_mem    = valid_i && (memop_i != segre_pkg::MEMOP_NONE);
// Stays high up to the ack cycle so decode captures after write-back
assign ex_busy_o = is_mem && !dc_ack_i;

// Data port request, raised one cycle after the memop enters execute
always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        dc_req_o <= 1'b0;
    end else begin
        dc_req_o <= is_mem && !dc_ack_i;
    end
end

always_ff @(posedge clk_i) begin
    dc_we_o    <= (memop_i == segre_pkg::MEMOP_STORE);
    dc_addr_o  <= {alu_res[segre_pkg::ADDR_SIZE-1:2], 2'b00};
    dc_wdata_o <= store_data_i;
end

// Write-back, loads only in their ack cycle
assign rf_we_o    = valid_i && rf_we_i && (memop_i != segre_pkg::MEMOP_LOAD || dc_ack_i);
assign rf_waddr_o = rf_waddr_i;

always_comb begin
    if (memop_i == segre_pkg::MEMOP_LOAD) begin
        rf_wdata_o = dc_rdata_i;
    end else if (br_type_i == segre_pkg::BR_JAL) begin
        rf_wdata_o = pc_i + 4;
    end else begin
        rf_wdata_o = alu_res;
    end
end

endmodule : segre_pipeline_wrapper

// File: source/segre_pkg.sv
package segre_pkg;

    // Datapath widths
    localparam int WORD_SIZE     = 32;
    localparam int ADDR_SIZE     = 32;
    localparam int REG_ADDR_SIZE = 5;

    // First fetch after reset
    localparam logic [ADDR_SIZE-1:0] RESET_PC = '0;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_opcode_e;

    typedef enum logic [1:0] {
        MEMOP_NONE,
        MEMOP_LOAD,
        MEMOP_STORE
    } memop_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_type_e;

endpackage : segre_pkg

// File: source/segre_register_file.sv
`timescale 1ns/10ps

module segre_register_file (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] raddr_a_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] raddr_b_i,
    input  logic                                we_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] waddr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     wdata_i,
    output logic [segre_pkg::WORD_SIZE-1:0]     data_a_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     data_b_o
);

logic [segre_pkg::WORD_SIZE-1:0] regs [2**segre_pkg::REG_ADDR_SIZE];

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        for (int i = 0; i < 2**segre_pkg::REG_ADDR_SIZE; i++) begin
            regs[i] <= '0;
        end
    end else if (we_i && waddr_i != '0) begin
        regs[waddr_i] <= wdata_i;
    end
end

// x0 reads zero, a same-cycle write is seen by the reader
assign data_a_o = (raddr_a_i == '0) ? '0 :
                  (we_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
assign data_b_o = (raddr_b_i == '0) ? '0 :
                  (we_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule : segre_register_file

// File: tb.f
source/segre_pkg.sv
source/segre_if_stage.sv
source/segre_id_stage.sv
source/segre_pipeline_wrapper.sv
source/segre_register_file.sv
source/segre_mem_arbiter.sv
source/segre_core.sv
tb/segre_core_checker.sv
tb/segre_core_tb.sv

// File: tb/segre_core_checker.sv
`timescale 1ns/10ps

module segre_core_checker (
    input logic                            clk_i,
    input logic                            arst_n_i,
    input logic                            wb_cyc_i,
    input logic                            wb_stb_i,
    input logic                            wb_we_i,
    input logic [segre_pkg::ADDR_SIZE-1:0] wb_adr_i,
    input logic [segre_pkg::WORD_SIZE-1:0] wb_wdata_i,
    input logic                            wb_ack_i,
    input logic                            dc_req_i,
    input logic                            dc_ack_i
);

int unsigned fail_count = 0;

// Bus quiet in reset and right after release
reset_idle: assert property (@(posedge clk_i) !arst_n_i |-> !wb_cyc_i && !wb_stb_i)
    else begin
        fail_count++;
        $error("Bus active while in reset");
    end
release_idle: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !wb_cyc_i && !wb_stb_i)
    else begin
        fail_count++;
        $error("Bus active in first cycle after reset");
    end

// Wishbone classic handshake
stb_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_i |-> wb_cyc_i)
    else begin
        fail_count++;
        $error("stb raised without cyc");
    end
hold_request: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i) && $stable(wb_we_i))
    else begin
        fail_count++;
        $error("Request changed before ack");
    end
hold_wdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_i && wb_we_i && !wb_ack_i |=> $stable(wb_wdata_i))
    else begin
        fail_count++;
        $error("Write data changed before ack");
    end
drop_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_cyc_i && wb_ack_i |=> !wb_cyc_i)
    else begin
        fail_count++;
        $error("cyc still high after ack");
    end

// Stores come from a pending data request and only once per instruction
store_from_dc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_i && wb_we_i |-> dc_req_i)
    else begin
        fail_count++;
        $error("Bus write without a store request");
    end
no_repeat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dc_ack_i |=> !dc_req_i)
    else begin
        fail_count++;
        $error("Data request repeated after ack");
    end

endmodule : segre_core_checker

// File: tb/segre_core_tb.sv
`timescale 1ns/10ps

module segre_core_tb;

localparam int CLK_PERIOD  = 8;
localparam int SEED        = 41016;
localparam int MEM_WORDS   = 128;
localparam int PROG_LEN    = 31;
localparam int N_STORES    = 11;
localparam int WATCHDOG_NS = PROG_LEN * 4 * 5 * CLK_PERIOD;
localparam logic [31:0] DATA_BASE = 32'h100;
localparam logic [31:0] OP_A      = 32'd1234;
// -77 in two's complement
localparam logic [31:0] OP_B      = 32'hFFFF_FFB3;

logic        clk_i;
logic        arst_n_i;
logic [31:0] wb_dat_i;
logic        wb_ack_i;
logic        wb_cyc_o;
logic        wb_stb_o;
logic        wb_we_o;
logic [31:0] wb_adr_o;
logic [31:0] wb_dat_o;

logic [31:0] mem [MEM_WORDS];
logic [31:0] exp_addr [N_STORES];
logic [31:0] exp_data [N_STORES];
string       exp_name [N_STORES];
logic [31:0] wr_addr_q [$];
logic [31:0] wr_data_q [$];
int          errors = 0;
int          checked = 0;
bit          first_seen = 1'b0;

segre_core dut0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o)
);

bind segre_core segre_core_checker checker0 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wb_cyc_i   (wb_cyc_o),
    .wb_stb_i   (wb_stb_o),
    .wb_we_i    (wb_we_o),
    .wb_adr_i   (wb_adr_o),
    .wb_wdata_i (wb_dat_o),
    .wb_ack_i   (wb_ack_i),
    .dc_req_i   (dc_req),
    .dc_ack_i   (dc_ack)
);

// Instruction encoders
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, segre_pkg::OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], segre_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], segre_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, segre_pkg::OPC_JAL};
endfunction

task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = 32'hA5A5_0000 ^ (i * 4);
    end
    mem[0]  = i_type(DATA_BASE[11:0], 0, 3'b000, 1, segre_pkg::OPC_OPIMM);
    mem[1]  = i_type(OP_A[11:0], 0, 3'b000, 2, segre_pkg::OPC_OPIMM);
    mem[2]  = i_type(OP_B[11:0], 0, 3'b000, 3, segre_pkg::OPC_OPIMM);
    mem[3]  = r_type(7'h00, 3, 2, 3'b000, 4);
    mem[4]  = s_type(12'd0, 4, 1);
    mem[5]  = r_type(7'h20, 3, 2, 3'b000, 5);
    mem[6]  = s_type(12'd4, 5, 1);
    mem[7]  = r_type(7'h00, 3, 2, 3'b111, 6);
    mem[8]  = s_type(12'd8, 6, 1);
    mem[9]  = r_type(7'h00, 3, 2, 3'b110, 7);
    mem[10] = s_type(12'd12, 7, 1);
    mem[11] = r_type(7'h00, 3, 2, 3'b100, 8);
    mem[12] = s_type(12'd16, 8, 1);
    mem[13] = r_type(7'h00, 2, 3, 3'b010, 9);
    mem[14] = s_type(12'd20, 9, 1);
    mem[15] = i_type(12'd100, 9, 3'b000, 10, segre_pkg::OPC_OPIMM);
    mem[16] = s_type(12'd24, 10, 1);
    mem[17] = {20'hABCDE, 5'd11, segre_pkg::OPC_LUI};
    mem[18] = i_type(12'h123, 11, 3'b000, 11, segre_pkg::OPC_OPIMM);
    mem[19] = s_type(12'd28, 11, 1);
    mem[20] = i_type(12'd0, 1, 3'b010, 12, segre_pkg::OPC_LOAD);
    mem[21] = i_type(12'd1, 12, 3'b000, 12, segre_pkg::OPC_OPIMM);
    mem[22] = s_type(12'd32, 12, 1);
    // Taken BEQ skips a store
    mem[23] = b_type(13'd8, 2, 2, 3'b000);
    mem[24] = s_type(12'h80, 2, 1);
    // Not-taken BNE falls through to its store
    mem[25] = b_type(13'd8, 2, 2, 3'b001);
    mem[26] = s_type(12'd36, 3, 1);
    mem[27] = j_type(21'd8, 13);
    mem[28] = s_type(12'h84, 2, 1);
    mem[29] = s_type(12'd40, 13, 1);
    mem[30] = j_type(21'd0, 0);
endtask

// Store results from RV32I semantics in program order
task automatic build_expected();
    exp_name = '{"add", "sub", "and", "or", "xor", "slt", "addi", "lui",
                 "load_use", "bne_fall", "jal_link"};
    exp_data[0]  = OP_A + OP_B;
    exp_data[1]  = OP_A - OP_B;
    exp_data[2]  = OP_A & OP_B;
    exp_data[3]  = OP_A | OP_B;
    exp_data[4]  = OP_A ^ OP_B;
    exp_data[5]  = ($signed(OP_B) < $signed(OP_A)) ? 32'd1 : 32'd0;
    exp_data[6]  = exp_data[5] + 32'd100;
    exp_data[7]  = 32'hABCDE000 + 32'h123;
    exp_data[8]  = exp_data[0] + 32'd1;
    exp_data[9]  = OP_B;
    exp_data[10] = 32'd27 * 4 + 4;
    for (int i = 0; i < N_STORES; i++) begin
        exp_addr[i] = DATA_BASE + i * 4;
    end
endtask

task automatic compare_writes();
    logic [31:0] addr;
    logic [31:0] data;
    while (wr_addr_q.size() > 0) begin
        addr = wr_addr_q.pop_front();
        data = wr_data_q.pop_front();
        assert (checked < N_STORES) else begin
            errors++;
            $display("Unexpected extra store of %h to address %h", data, addr);
        end
        if (checked < N_STORES) begin
            assert (addr == exp_addr[checked]) else begin
                errors++;
                $display("Error %s address: expected %h actual %h",
                         exp_name[checked], exp_addr[checked], addr);
            end
            assert (data == exp_data[checked]) else begin
                errors++;
                $display("Error %s data: expected %h actual %h",
                         exp_name[checked], exp_data[checked], data);
            end
        end
        checked++;
    end
endtask

task automatic serve_access();
    int unsigned idx;
    idx = wb_adr_o >> 2;
    if (!first_seen) begin
        first_seen = 1'b1;
        assert (wb_adr_o == segre_pkg::RESET_PC) else begin
            errors++;
            $display("Error reset_pc: expected %h actual %h", segre_pkg::RESET_PC, wb_adr_o);
        end
    end
    assert (idx < MEM_WORDS) else begin
        errors++;
        $display("Bus access outside the memory at address %h", wb_adr_o);
    end
    if (idx < MEM_WORDS && wb_we_o) begin
        mem[idx] = wb_dat_o;
        wr_addr_q.push_back(wb_adr_o);
        wr_data_q.push_back(wb_dat_o);
        compare_writes();
    end else if (idx < MEM_WORDS) begin
        wb_dat_i = mem[idx];
    end
    wb_ack_i = 1'b1;
endtask

initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
end

// Wishbone slave with 0 to 3 wait states per access
initial begin : wishbone_memory
    int          wait_left;
    bit          busy;
    int unsigned seed_draw;
    seed_draw = $urandom(SEED);
    wait_left = 0;
    busy = 1'b0;
    forever begin
        @(posedge clk_i);
        #1;
        wb_ack_i = 1'b0;
        if (wb_cyc_o && wb_stb_o) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
                serve_access();
                busy = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end
end

initial begin : run_test
    arst_n_i = 1'b0;
    wb_ack_i = 1'b0;
    wb_dat_i = '0;
    load_program();
    build_expected();
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    wait (checked >= N_STORES);
    // Let any stray store reach the bus
    repeat (20) @(posedge clk_i);
    $display("Error counts: %0d testbench, %0d assertion", errors, dut0.checker0.fail_count);
    if (errors == 0 && dut0.checker0.fail_count == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d of %0d stores seen",
             WATCHDOG_NS, checked, N_STORES);
    for (int i = checked; i < N_STORES; i++) begin
        $display("Store %s never appeared on the bus", exp_name[i]);
    end
    $display("Error counts: %0d testbench, %0d assertion", errors, dut0.checker0.fail_count);
    $display("SOME TESTS FAILED");
    $finish;
end

endmodule : segre_core_tb
